//--- act_defs.svh
`ifndef ACT_DEFS_SVH
`define ACT_DEFS_SVH

// Row address width kept small for simulation
`define ACT_ADDR_WIDTH 10

// SRAM bank organisation
`define ACT_NUM_BANKS 32
`define ACT_BANK_WIDTH 8

// Port widths
`define ACT_NARROW_WIDTH 32
`define ACT_WIDE_WIDTH 256

// Banks covered by a narrow access from bank 0 up
`define ACT_NARROW_BANKS 4

`endif

//--- act_pkg.sv
`include "act_defs.svh"

package act_pkg;

    // Row address into the banked SRAM
    typedef logic [`ACT_ADDR_WIDTH-1:0] row_addr_t;

    // Host word of four activation bytes
    typedef logic [`ACT_NARROW_WIDTH-1:0] narrow_word_t;

    // Full row with bank k in bits 8k+7:8k
    typedef logic [`ACT_WIDE_WIDTH-1:0] wide_row_t;

    // One bit per bank
    typedef logic [`ACT_NUM_BANKS-1:0] bank_mask_t;

    // Burst length one bit wider than an address
    typedef logic [`ACT_ADDR_WIDTH:0] row_count_t;

endpackage

//--- sram_banked.sv
`include "act_defs.svh"

module sram_banked (
    input  logic              clk,
    input  logic              nrst,
    input  logic              wr_en_i,
    input  act_pkg::bank_mask_t bank_mask_i,
    input  act_pkg::row_addr_t  addr_i,
    input  act_pkg::wide_row_t  wr_data_i,
    output act_pkg::wide_row_t  rd_data_o
);

    localparam int DEPTH = 1 << `ACT_ADDR_WIDTH;
    localparam int BW    = `ACT_BANK_WIDTH;

    // One byte-wide array per bank on a shared row address
    for (genvar b = 0; b < `ACT_NUM_BANKS; b++) begin : g_bank
        logic [BW-1:0] mem [DEPTH];
        logic [BW-1:0] rd_byte_q;

        // Banks read as zero after reset
        always_ff @(posedge clk or negedge nrst) begin
            if (!nrst) begin
                for (int r = 0; r < DEPTH; r++) begin
                    mem[r] <= '0;
                end
            end else if (wr_en_i && bank_mask_i[b]) begin
                mem[addr_i] <= wr_data_i[b*BW +: BW]; // Only masked banks change
            end
        end

        always_ff @(posedge clk or negedge nrst) begin
            if (!nrst) begin
                rd_byte_q <= '0;
            end else if (!wr_en_i) begin
                rd_byte_q <= mem[addr_i]; // Read every cycle without a write
            end
        end

        assign rd_data_o[b*BW +: BW] = rd_byte_q;
    end

endmodule

//--- activation_buffer.sv
`include "act_defs.svh"

module activation_buffer (
    input  logic                  clk,
    input  logic                  nrst,

    // Narrow write port into banks 0 to 3
    input  logic                  wr_en_1_i,
    input  act_pkg::row_addr_t    wr_addr_1_i,
    input  act_pkg::narrow_word_t wr_data_1_i,

    // Narrow read port
    input  logic                  rd_en_1_i,
    input  act_pkg::row_addr_t    rd_addr_1_i,
    output act_pkg::narrow_word_t rd_data_1_o,

    // Wide read port
    input  logic                  rd_en_2_i,
    input  act_pkg::row_addr_t    rd_addr_2_i,
    output act_pkg::wide_row_t    rd_data_2_o,
    output logic                  rd_ready_2_o,

    output logic                  wr_ready_o
);

    localparam int BW = `ACT_BANK_WIDTH;
    localparam int NW = `ACT_NARROW_WIDTH;

    localparam act_pkg::bank_mask_t NARROW_MASK =
        act_pkg::bank_mask_t'((1 << `ACT_NARROW_BANKS) - 1);

    logic                sram_wr_en;
    act_pkg::bank_mask_t sram_mask;
    act_pkg::row_addr_t  sram_addr;
    act_pkg::wide_row_t  sram_wr_data;
    act_pkg::wide_row_t  sram_rd_data;
    act_pkg::wide_row_t  narrow_row;  // Narrow word placed into its banks
    act_pkg::wide_row_t  rd_row_q;    // Held copy of the last read row
    act_pkg::wide_row_t  rd_row;
    logic                rd_grant;
    logic                rd_grant_q;

    sram_banked i_sram_banked (
        .clk         (clk),
        .nrst        (nrst),
        .wr_en_i     (sram_wr_en),
        .bank_mask_i (sram_mask),
        .addr_i      (sram_addr),
        .wr_data_i   (sram_wr_data),
        .rd_data_o   (sram_rd_data)
    );

    // Most significant byte of the word lands in bank 0
    always_comb begin
        narrow_row = '0;
        for (int k = 0; k < `ACT_NARROW_BANKS; k++) begin
            narrow_row[k*BW +: BW] = wr_data_1_i[NW-1-k*BW -: BW];
        end
    end

    assign rd_grant = rd_en_1_i | rd_en_2_i;

    always_comb begin
        sram_wr_en   = 1'b0;
        sram_mask    = '0;
        sram_addr    = '0;
        sram_wr_data = '0;
        wr_ready_o   = 1'b0;
        rd_ready_2_o = 1'b0;
        if (rd_en_1_i) begin
            sram_addr = rd_addr_1_i;  // Narrow read wins
        end else if (rd_en_2_i) begin
            sram_addr    = rd_addr_2_i;
            rd_ready_2_o = 1'b1;
        end else if (wr_en_1_i) begin
            sram_wr_en   = 1'b1;      // Write only when no read is present
            sram_mask    = NARROW_MASK;
            sram_addr    = wr_addr_1_i;
            sram_wr_data = narrow_row;
            wr_ready_o   = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_grant_q <= 1'b0;
            rd_row_q   <= '0;
        end else begin
            rd_grant_q <= rd_grant;
            if (rd_grant_q) begin
                rd_row_q <= sram_rd_data; // Keep the row once the SRAM moves on
            end
        end
    end

    assign rd_row      = rd_grant_q ? sram_rd_data : rd_row_q;
    assign rd_data_2_o = rd_row;

    // Rebuild the host word in write order
    always_comb begin
        rd_data_1_o = '0;
        for (int k = 0; k < `ACT_NARROW_BANKS; k++) begin
            rd_data_1_o[NW-1-k*BW -: BW] = rd_row[k*BW +: BW];
        end
    end

endmodule

//--- act_loader.sv
module act_loader (
    input  logic                  clk,
    input  logic                  nrst,

    // Host side
    input  logic                  load_start_i,
    input  act_pkg::row_addr_t    load_base_i,
    input  logic                  load_valid_i,
    input  act_pkg::narrow_word_t load_data_i,
    output logic                  load_busy_o,

    // Narrow write into the buffer
    output logic                  wr_en_o,
    output act_pkg::row_addr_t    wr_addr_o,
    output act_pkg::narrow_word_t wr_data_o,
    input  logic                  wr_ready_i
);

    act_pkg::row_addr_t    addr_q;
    act_pkg::narrow_word_t hold_q;
    logic                  pend_q;   // Word waiting for its write
    logic                  wr_done;

    assign wr_done = pend_q & wr_ready_i;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            addr_q <= '0;
        end else if (load_start_i) begin
            addr_q <= load_base_i;   // New block restarts at base
        end else if (wr_done) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hold_q <= '0;
            pend_q <= 1'b0;
        end else if (load_valid_i) begin
            hold_q <= load_data_i;
            pend_q <= 1'b1;
        end else if (wr_done) begin
            pend_q <= 1'b0;
        end
    end

    // Write is held steady until the buffer takes it
    assign wr_en_o     = pend_q;
    assign wr_addr_o   = addr_q;
    assign wr_data_o   = hold_q;
    assign load_busy_o = pend_q;

endmodule

//--- act_fetcher.sv
module act_fetcher (
    input  logic                clk,
    input  logic                nrst,

    // Burst request
    input  logic                fetch_start_i,
    input  act_pkg::row_addr_t  fetch_base_i,
    input  act_pkg::row_count_t fetch_count_i,
    output logic                fetch_busy_o,

    // Wide read into the buffer
    output logic                rd_en_o,
    output act_pkg::row_addr_t  rd_addr_o,
    input  logic                rd_ready_i,
    input  act_pkg::wide_row_t  rd_data_i,

    // Vector stream to the array
    output logic                vec_valid_o,
    output act_pkg::wide_row_t  vec_data_o
);

    act_pkg::row_addr_t  addr_q;
    act_pkg::row_count_t remain_q;  // Rows not yet granted
    logic                busy_q;
    logic                vec_valid_q;
    logic                grant;

    assign rd_en_o   = (remain_q != '0);
    assign rd_addr_o = addr_q;
    assign grant     = rd_en_o & rd_ready_i;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            addr_q   <= '0;
            remain_q <= '0;
        end else if (fetch_start_i) begin
            addr_q   <= fetch_base_i;
            remain_q <= fetch_count_i;
        end else if (grant) begin
            addr_q   <= addr_q + 1'b1;   // Next row issued back to back
            remain_q <= remain_q - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            vec_valid_q <= 1'b0;
        end else begin
            vec_valid_q <= grant;        // Row data arrives one cycle later
        end
    end

    // Busy until the cycle of the last vector has passed
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            busy_q <= 1'b0;
        end else if (fetch_start_i) begin
            busy_q <= 1'b1;
        end else if (busy_q && remain_q == '0) begin
            busy_q <= 1'b0;
        end
    end

    assign fetch_busy_o = busy_q;
    assign vec_valid_o  = vec_valid_q;
    assign vec_data_o   = rd_data_i;

endmodule

//--- act_subsystem_top.sv
module act_subsystem_top (
    input  logic                  clk,
    input  logic                  nrst,

    // Host loading
    input  logic                  load_start_i,
    input  act_pkg::row_addr_t    load_base_i,
    input  logic                  load_valid_i,
    input  act_pkg::narrow_word_t load_data_i,
    output logic                  load_busy_o,

    // Host readback
    input  logic                  host_rd_en_i,
    input  act_pkg::row_addr_t    host_rd_addr_i,
    output act_pkg::narrow_word_t host_rd_data_o,

    // Array side
    input  logic                  fetch_start_i,
    input  act_pkg::row_addr_t    fetch_base_i,
    input  act_pkg::row_count_t   fetch_count_i,
    output logic                  fetch_busy_o,
    output logic                  vec_valid_o,
    output act_pkg::wide_row_t    vec_data_o
);

    logic                  wr_en_1;
    act_pkg::row_addr_t    wr_addr_1;
    act_pkg::narrow_word_t wr_data_1;
    logic                  wr_ready;
    logic                  rd_en_2;
    act_pkg::row_addr_t    rd_addr_2;
    act_pkg::wide_row_t    rd_data_2;
    logic                  rd_ready_2;

    act_loader i_act_loader (
        .clk (clk), .nrst (nrst),
        .load_start_i (load_start_i), .load_base_i (load_base_i),
        .load_valid_i (load_valid_i), .load_data_i (load_data_i),
        .load_busy_o  (load_busy_o),
        .wr_en_o (wr_en_1), .wr_addr_o (wr_addr_1), .wr_data_o (wr_data_1),
        .wr_ready_i (wr_ready)
    );

    activation_buffer i_activation_buffer (
        .clk (clk), .nrst (nrst),
        .wr_en_1_i (wr_en_1), .wr_addr_1_i (wr_addr_1), .wr_data_1_i (wr_data_1),
        .rd_en_1_i (host_rd_en_i), .rd_addr_1_i (host_rd_addr_i),
        .rd_data_1_o (host_rd_data_o),
        .rd_en_2_i (rd_en_2), .rd_addr_2_i (rd_addr_2), .rd_data_2_o (rd_data_2),
        .rd_ready_2_o (rd_ready_2), .wr_ready_o (wr_ready)
    );

    act_fetcher i_act_fetcher (
        .clk (clk), .nrst (nrst),
        .fetch_start_i (fetch_start_i), .fetch_base_i (fetch_base_i),
        .fetch_count_i (fetch_count_i), .fetch_busy_o (fetch_busy_o),
        .rd_en_o (rd_en_2), .rd_addr_o (rd_addr_2),
        .rd_ready_i (rd_ready_2), .rd_data_i (rd_data_2),
        .vec_valid_o (vec_valid_o), .vec_data_o (vec_data_o)
    );

endmodule

//--- tb_act_subsystem.sv
`include "act_defs.svh"

module tb_act_subsystem;

    localparam int NB    = `ACT_NUM_BANKS;
    localparam int BW    = `ACT_BANK_WIDTH;
    localparam int DEPTH = 1 << `ACT_ADDR_WIDTH;
    localparam int NLOAD = 8;    // Words loaded in one block
    localparam int TMO   = 200;  // Cycles before a wait gives up

    logic                  clk;
    logic                  nrst;
    logic                  load_start_i;
    act_pkg::row_addr_t    load_base_i;
    logic                  load_valid_i;
    act_pkg::narrow_word_t load_data_i;
    logic                  load_busy_o;
    logic                  host_rd_en_i;
    act_pkg::row_addr_t    host_rd_addr_i;
    act_pkg::narrow_word_t host_rd_data_o;
    logic                  fetch_start_i;
    act_pkg::row_addr_t    fetch_base_i;
    act_pkg::row_count_t   fetch_count_i;
    logic                  fetch_busy_o;
    logic                  vec_valid_o;
    act_pkg::wide_row_t    vec_data_o;

    logic [BW-1:0]      model [NB][DEPTH];  // Expected bytes per bank and row
    act_pkg::row_addr_t load_row;           // Row the next loaded word lands in
    int                 errors;
    int                 checks;
    int                 tests;
    int                 err_mark;

    act_subsystem_top i_act_subsystem_top (
        .clk (clk), .nrst (nrst),
        .load_start_i (load_start_i), .load_base_i (load_base_i),
        .load_valid_i (load_valid_i), .load_data_i (load_data_i),
        .load_busy_o (load_busy_o),
        .host_rd_en_i (host_rd_en_i), .host_rd_addr_i (host_rd_addr_i),
        .host_rd_data_o (host_rd_data_o),
        .fetch_start_i (fetch_start_i), .fetch_base_i (fetch_base_i),
        .fetch_count_i (fetch_count_i), .fetch_busy_o (fetch_busy_o),
        .vec_valid_o (vec_valid_o), .vec_data_o (vec_data_o)
    );

    always #10 clk = ~clk;

    // Bank k shows up in bits 8k+7:8k of a row
    function automatic act_pkg::wide_row_t model_row(input act_pkg::row_addr_t r);
        act_pkg::wide_row_t v;
        for (int k = 0; k < NB; k++) begin
            v[k*BW +: BW] = model[k][r];
        end
        return v;
    endfunction

    // Bank k holds byte 3-k of a host word
    function automatic act_pkg::narrow_word_t model_word(input act_pkg::row_addr_t r);
        act_pkg::narrow_word_t w;
        for (int k = 0; k < `ACT_NARROW_BANKS; k++) begin
            w[BW*(`ACT_NARROW_BANKS-1-k) +: BW] = model[k][r];
        end
        return w;
    endfunction

    task automatic compare_value(input string what, input logic [`ACT_WIDE_WIDTH-1:0] got,
                                 input logic [`ACT_WIDE_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s wrong, expected %h, got %h", $time, what, exp, got);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("Test %0d %s: %s", tests, name, (errors == err_mark) ? "passed" : "failed");
        err_mark = errors;
    endtask

    // Data is valid in the cycle after the strobe
    task automatic host_read(input act_pkg::row_addr_t r, output act_pkg::narrow_word_t d);
        host_rd_en_i   = 1'b1;
        host_rd_addr_i = r;
        @(posedge clk);
        #2;
        d            = host_rd_data_o;
        host_rd_en_i = 1'b0;
    endtask

    task automatic start_load(input act_pkg::row_addr_t base);
        load_start_i = 1'b1;
        load_base_i  = base;
        @(posedge clk);
        #2;
        load_start_i = 1'b0;
        load_row     = base;
    endtask

    // Optionally keeps host reads going to stall the pending write
    task automatic load_word(input act_pkg::narrow_word_t w, input int hold_cycles);
        int n;
        load_valid_i = 1'b1;
        load_data_i  = w;
        @(posedge clk);
        #2;
        load_valid_i = 1'b0;
        for (int i = 0; i < hold_cycles; i++) begin
            compare_value("load_busy_o under host reads", load_busy_o, 1'b1);
            host_rd_en_i   = 1'b1;
            host_rd_addr_i = act_pkg::row_addr_t'($urandom);
            @(posedge clk);
            #2;
        end
        host_rd_en_i = 1'b0;
        n = 0;
        while (load_busy_o && n < TMO) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (load_busy_o) stop_on_timeout("load_busy_o to fall");
        for (int k = 0; k < `ACT_NARROW_BANKS; k++) begin
            model[k][load_row] = w[BW*(`ACT_NARROW_BANKS-1-k) +: BW];
        end
        load_row = load_row + 1'b1;
    endtask

    task automatic run_fetch(input act_pkg::row_addr_t base, input int count,
                             input bit with_reads);
        int got;
        int n;
        fetch_start_i = 1'b1;
        fetch_base_i  = base;
        fetch_count_i = act_pkg::row_count_t'(count);
        @(posedge clk);
        #2;
        fetch_start_i = 1'b0;
        got = 0;
        n   = 0;
        while (fetch_busy_o && n < TMO) begin
            if (vec_valid_o) begin
                compare_value($sformatf("vector %0d", got), vec_data_o,
                              model_row(act_pkg::row_addr_t'(base + got)));
                got++;
            end
            host_rd_en_i   = with_reads ? 1'($urandom % 2) : 1'b0;
            host_rd_addr_i = act_pkg::row_addr_t'($urandom);
            @(posedge clk);
            #2;
            n++;
        end
        host_rd_en_i = 1'b0;
        if (fetch_busy_o) stop_on_timeout("fetch_busy_o to fall");
        compare_value("vector count", got, count);
    endtask

    initial begin
        act_pkg::row_addr_t    base;
        act_pkg::row_addr_t    r;
        act_pkg::narrow_word_t d;
        void'($urandom(32'h7da7));
        clk = 1'b0;
        nrst = 1'b0;
        load_start_i = 1'b0;
        load_base_i = '0;
        load_valid_i = 1'b0;
        load_data_i = '0;
        host_rd_en_i = 1'b0;
        host_rd_addr_i = '0;
        fetch_start_i = 1'b0;
        fetch_base_i = '0;
        fetch_count_i = '0;
        load_row = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        err_mark = 0;
        for (int k = 0; k < NB; k++) begin
            for (int j = 0; j < DEPTH; j++) begin
                model[k][j] = '0;
            end
        end
        repeat (5) @(posedge clk);
        #2;
        nrst = 1'b1;

        compare_value("load_busy_o after reset", load_busy_o, 1'b0);
        compare_value("fetch_busy_o after reset", fetch_busy_o, 1'b0);
        compare_value("vec_valid_o after reset", vec_valid_o, 1'b0);
        r = act_pkg::row_addr_t'($urandom);
        host_read(r, d);
        compare_value("readback after reset", d, model_word(r));
        report_test("reset state");

        base = act_pkg::row_addr_t'($urandom % (DEPTH - 2 * NLOAD));
        start_load(base);
        for (int i = 0; i < NLOAD; i++) begin
            load_word($urandom, 0);
        end
        for (int i = 0; i < NLOAD; i++) begin
            r = base + i;
            host_read(r, d);
            compare_value($sformatf("readback of row %0d", r), d, model_word(r));
        end
        // Idle cycle, the last read row must still be presented
        @(posedge clk);
        #2;
        compare_value("readback held after idle cycle", host_rd_data_o, model_word(r));
        report_test("load and readback");

        run_fetch(base, 1 + $urandom % NLOAD, 1'b0);
        report_test("fetch burst");

        run_fetch(base, NLOAD, 1'b1);
        report_test("fetch with host reads");

        load_word($urandom, 3 + $urandom % 5);
        r = load_row - 1'b1;
        host_read(r, d);
        compare_value("readback after stalled write", d, model_word(r));
        report_test("reads over a pending write");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
act_pkg.sv
sram_banked.sv
activation_buffer.sv
act_loader.sv
act_fetcher.sv
act_subsystem_top.sv
tb_act_subsystem.sv

//--- Bender.yml
package:
  name: act_subsystem

export_include_dirs:
  - .

sources:
  - act_pkg.sv
  - sram_banked.sv
  - activation_buffer.sv
  - act_loader.sv
  - act_fetcher.sv
  - act_subsystem_top.sv
  - target: test
    files:
      - tb_act_subsystem.sv
